//--- hdl/rp_loop_pkg.sv
// Shared constants and types for the two-channel analog front end.
// Modules take these through a wildcard import in the body; port
// declarations use scoped names.

package rp_loop_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // channel counts and sample widths
  ////////////////////////////////////////////////////////////////////////////

  // ADC/DAC channels
  localparam int unsigned CHN_NUM = 2;
  // raw ADC word, also oscilloscope width
  localparam int unsigned ADC_DW = 16;
  // generator sample and DAC bus width
  localparam int unsigned DAC_DW = 14;
  // generator to oscilloscope alignment
  localparam int unsigned LOOP_SHIFT = ADC_DW - DAC_DW;

  // PDM outputs and level width
  localparam int unsigned PDM_CHN = 4;
  localparam int unsigned PDM_DW = 8;

  ////////////////////////////////////////////////////////////////////////////
  // configuration port
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned CFG_AW = 2;
  localparam int unsigned CFG_DW = 16;

  // register map, address 3 is acked and ignored
  localparam logic [CFG_AW-1:0] CFG_ADDR_LOOP = 2'd0;
  localparam logic [CFG_AW-1:0] CFG_ADDR_PDM_LO = 2'd1;
  localparam logic [CFG_AW-1:0] CFG_ADDR_PDM_HI = 2'd2;

  // offset binary mid-scale, what the DAC sees for a zero sample
  localparam logic [DAC_DW-1:0] DAC_IDLE = {1'b0, {(DAC_DW-1){1'b1}}};

  // loop control view
  typedef struct packed {
    logic [CFG_DW-CHN_NUM-1:0] rsvd;
    logic [CHN_NUM-1:0]        loop_en;
  } cfg_loop_t;

  // PDM pair view, odd channel in the high byte
  typedef struct packed {
    logic [PDM_DW-1:0] lvl_odd;
    logic [PDM_DW-1:0] lvl_even;
  } cfg_pdm_t;

  // one written word, decoded by address
  typedef union packed {
    cfg_loop_t loop;
    cfg_pdm_t  pdm;
  } cfg_word_u;

endpackage: rp_loop_pkg

//--- hdl/cfg_regs.sv
// Configuration register bank behind a four-phase req/ack port.
// Holds the per-channel loopback bits and the four PDM levels.
// A write lands on the edge that raises ack; ack drops once req is low.

`timescale 1ns/10ps

module cfg_regs (
  // clock and reset
  input  logic                                                   adc_clk,
  input  logic                                                   top_rst,
  // host side handshake
  input  logic                                                   cfg_req_i,
  input  logic                            [rp_loop_pkg::CFG_AW-1:0] cfg_addr_i,
  input  rp_loop_pkg::cfg_word_u                                  cfg_dat_i,
  output logic                                                   cfg_ack_o,
  // register outputs
  output logic                           [rp_loop_pkg::CHN_NUM-1:0] loop_en_o,
  output logic [rp_loop_pkg::PDM_CHN-1:0][rp_loop_pkg::PDM_DW-1:0]  pdm_lvl_o
);

  import rp_loop_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // handshake
  ////////////////////////////////////////////////////////////////////////////

  logic wr_stb;

  // new request, not yet acked
  assign wr_stb = cfg_req_i & ~cfg_ack_o;

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      cfg_ack_o <= 1'b0;
    end else if (wr_stb) begin
      // phase 2, ack together with the write
      cfg_ack_o <= 1'b1;
    end else if (~cfg_req_i) begin
      // phase 4, host has let go
      cfg_ack_o <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // register bank
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      loop_en_o <= '0;
      pdm_lvl_o <= '0;
    end else if (wr_stb) begin
      case (cfg_addr_i)
        CFG_ADDR_LOOP: begin
          // reserved bits are dropped
          loop_en_o <= cfg_dat_i.loop.loop_en;
        end
        CFG_ADDR_PDM_LO: begin
          // channels 0 and 1
          pdm_lvl_o[0] <= cfg_dat_i.pdm.lvl_even;
          pdm_lvl_o[1] <= cfg_dat_i.pdm.lvl_odd;
        end
        CFG_ADDR_PDM_HI: begin
          // channels 2 and 3
          pdm_lvl_o[2] <= cfg_dat_i.pdm.lvl_even;
          pdm_lvl_o[3] <= cfg_dat_i.pdm.lvl_odd;
        end
        default: begin
          // unmapped, acked with no effect
        end
      endcase
    end
  end

endmodule: cfg_regs

//--- hdl/chan_path.sv
// Data path of one analog channel.
// ADC side: register the raw word, fix the negative slope offset binary
// into two's complement, register again toward the oscilloscope.
// DAC side: generator sample back to negative slope offset binary.
// The loop bit routes the generator to the oscilloscope and freezes the DAC.

`timescale 1ns/10ps

module chan_path (
  // clock and reset
  input  logic                             adc_clk,
  input  logic                             top_rst,
  // ADC input and generator sample
  input  logic [rp_loop_pkg::ADC_DW-1:0]   adc_dat_i,
  input  logic [rp_loop_pkg::DAC_DW-1:0]   gen_dat_i,
  // loopback control
  input  logic                             loop_en_i,
  // oscilloscope and DAC words
  output logic [rp_loop_pkg::ADC_DW-1:0]   osc_dat_o,
  output logic [rp_loop_pkg::DAC_DW-1:0]   dac_word_o
);

  import rp_loop_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // first stage, input registers
  ////////////////////////////////////////////////////////////////////////////

  logic [ADC_DW-1:0] adc_raw;
  logic [DAC_DW-1:0] gen_raw;
  logic [ADC_DW-1:0] adc_cnv;
  logic [ADC_DW-1:0] gen_osc;

  // raw samples, one cycle behind the pins
  always_ff @(posedge adc_clk) begin
    adc_raw <= adc_dat_i;
    gen_raw <= gen_dat_i;
  end

  // keep the sign bit, invert the magnitude
  assign adc_cnv = {adc_raw[ADC_DW-1], ~adc_raw[ADC_DW-2:0]};

  // generator scaled up to oscilloscope width
  assign gen_osc = {gen_raw, {LOOP_SHIFT{1'b0}}};

  ////////////////////////////////////////////////////////////////////////////
  // second stage, oscilloscope output
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      osc_dat_o <= '0;
    end else if (loop_en_i) begin
      osc_dat_o <= gen_osc;
    end else begin
      osc_dat_o <= adc_cnv;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // DAC word
  ////////////////////////////////////////////////////////////////////////////

  // held while looped back, mid-scale out of reset
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      dac_word_o <= DAC_IDLE;
    end else if (~loop_en_i) begin
      dac_word_o <= {gen_dat_i[DAC_DW-1], ~gen_dat_i[DAC_DW-2:0]};
    end
  end

endmodule: chan_path

//--- hdl/dac_interleave.sv
// Puts both channel DAC words onto the single DAC bus.
// Select toggles every cycle; channel 0 goes out while select is low,
// channel 1 while it is high. The bus word is registered.

`timescale 1ns/10ps

module dac_interleave (
  // clock and reset
  input  logic                                                      adc_clk,
  input  logic                                                      top_rst,
  // per-channel words
  input  logic [rp_loop_pkg::CHN_NUM-1:0][rp_loop_pkg::DAC_DW-1:0]  dac_word_i,
  // shared DAC bus
  output logic                           [rp_loop_pkg::DAC_DW-1:0]  dac_dat_o,
  output logic                                                      dac_sel_o
);

  import rp_loop_pkg::*;

  logic sel_nxt;

  // select value for the coming cycle
  assign sel_nxt = ~dac_sel_o;

  ////////////////////////////////////////////////////////////////////////////
  // select toggle
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      dac_sel_o <= 1'b0;
    end else begin
      dac_sel_o <= sel_nxt;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // bus word
  ////////////////////////////////////////////////////////////////////////////

  // word picked ahead so it lines up with the select it belongs to
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      dac_dat_o <= DAC_IDLE;
    end else begin
      dac_dat_o <= dac_word_i[sel_nxt];
    end
  end

endmodule: dac_interleave

//--- hdl/pdm_gen.sv
// Four first-order PDM modulators.
// Each adds its level into an accumulator every cycle and drives
// the registered carry, so the duty is level/256.

`timescale 1ns/10ps

module pdm_gen (
  // clock and reset
  input  logic                                                      adc_clk,
  input  logic                                                      top_rst,
  // levels from the register bank
  input  logic [rp_loop_pkg::PDM_CHN-1:0][rp_loop_pkg::PDM_DW-1:0]  pdm_lvl_i,
  // 1-bit outputs
  output logic                           [rp_loop_pkg::PDM_CHN-1:0] pdm_o
);

  import rp_loop_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // per-channel accumulators
  ////////////////////////////////////////////////////////////////////////////

  generate
    for (genvar i = 0; i < PDM_CHN; i++) begin: for_pdm

      logic [PDM_DW-1:0] acc;
      logic [PDM_DW:0]   acc_sum;

      // one bit wider to catch the carry
      assign acc_sum = {1'b0, acc} + {1'b0, pdm_lvl_i[i]};

      always_ff @(posedge adc_clk, posedge top_rst) begin
        if (top_rst) begin
          acc      <= '0;
          pdm_o[i] <= 1'b0;
        end else begin
          // remainder wraps, carry becomes the pulse
          acc      <= acc_sum[PDM_DW-1:0];
          pdm_o[i] <= acc_sum[PDM_DW];
        end
      end

    end: for_pdm
  endgenerate

endmodule: pdm_gen

//--- hdl/rp_loop_top.sv
// Top level of the two-channel analog front end.
// Ties the configuration port, both channel paths, the DAC bus
// interleaver and the PDM outputs together. Single clock, adc_clk.

`timescale 1ns/10ps

module rp_loop_top (
  // clock and reset
  input  logic                                                      adc_clk,
  input  logic                                                      top_rst,
  // ADC
  input  logic [rp_loop_pkg::CHN_NUM-1:0][rp_loop_pkg::ADC_DW-1:0]  adc_dat_i,
  // generator samples
  input  logic [rp_loop_pkg::CHN_NUM-1:0][rp_loop_pkg::DAC_DW-1:0]  gen_dat_i,
  // oscilloscope words
  output logic [rp_loop_pkg::CHN_NUM-1:0][rp_loop_pkg::ADC_DW-1:0]  osc_dat_o,
  // DAC bus
  output logic                           [rp_loop_pkg::DAC_DW-1:0]  dac_dat_o,
  output logic                                                      dac_sel_o,
  // PDM outputs
  output logic                           [rp_loop_pkg::PDM_CHN-1:0] pdm_o,
  // configuration port
  input  logic                                                      cfg_req_i,
  input  logic                           [rp_loop_pkg::CFG_AW-1:0]  cfg_addr_i,
  input  rp_loop_pkg::cfg_word_u                                    cfg_dat_i,
  output logic                                                      cfg_ack_o
);

  import rp_loop_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // local signals
  ////////////////////////////////////////////////////////////////////////////

  // loopback bits, one per channel
  logic [CHN_NUM-1:0]             loop_en;
  // PDM levels
  logic [PDM_CHN-1:0][PDM_DW-1:0] pdm_lvl;
  // per-channel DAC words before interleaving
  logic [CHN_NUM-1:0][DAC_DW-1:0] dac_word;

  ////////////////////////////////////////////////////////////////////////////
  // configuration
  ////////////////////////////////////////////////////////////////////////////

  cfg_regs u_cfg_regs (
    .adc_clk    (adc_clk   ),
    .top_rst    (top_rst   ),
    .cfg_req_i  (cfg_req_i ),
    .cfg_addr_i (cfg_addr_i),
    .cfg_dat_i  (cfg_dat_i ),
    .cfg_ack_o  (cfg_ack_o ),
    .loop_en_o  (loop_en   ),
    .pdm_lvl_o  (pdm_lvl   )
  );

  ////////////////////////////////////////////////////////////////////////////
  // channel paths
  ////////////////////////////////////////////////////////////////////////////

  generate
    for (genvar i = 0; i < CHN_NUM; i++) begin: for_chn
      chan_path u_chan_path (
        .adc_clk    (adc_clk     ),
        .top_rst    (top_rst     ),
        .adc_dat_i  (adc_dat_i[i]),
        .gen_dat_i  (gen_dat_i[i]),
        .loop_en_i  (loop_en[i]  ),
        .osc_dat_o  (osc_dat_o[i]),
        .dac_word_o (dac_word[i] )
      );
    end: for_chn
  endgenerate

  ////////////////////////////////////////////////////////////////////////////
  // DAC bus and PDM
  ////////////////////////////////////////////////////////////////////////////

  // single rate, select flips every adc_clk
  dac_interleave u_dac_interleave (
    .adc_clk    (adc_clk  ),
    .top_rst    (top_rst  ),
    .dac_word_i (dac_word ),
    .dac_dat_o  (dac_dat_o),
    .dac_sel_o  (dac_sel_o)
  );

  pdm_gen u_pdm_gen (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .pdm_lvl_i (pdm_lvl),
    .pdm_o     (pdm_o  )
  );

endmodule: rp_loop_top

//--- test/tb_clk_gen.sv
// Clock and reset source for the front-end testbench.
// 100 ns adc_clk, reset held high for the first 10 cycles and
// released on a falling edge.

`timescale 1ns/10ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_o
);

  // free running clock, 50 ns per half period
  initial begin
    clk_o = 1'b0;
    forever #50 clk_o = ~clk_o;
  end

  // 10 rising edges in reset, release away from the active edge
  initial begin
    rst_o = 1'b1;
    repeat (10) @(posedge clk_o);
    @(negedge clk_o);
    rst_o = 1'b0;
  end

endmodule: tb_clk_gen

//--- test/tb_rp_loop_top.sv
// Testbench for the two-channel analog front end.
// Random ADC and generator samples go in on every falling edge; a model
// process tracks loop bits, PDM levels and the ack handshake, predicts
// every output and compares them on the falling edge after each clock.
// The main sequence covers capture, interleave, loopback, config and PDM.

`timescale 1ns/10ps

module tb_rp_loop_top;

  import rp_loop_pkg::*;

  // longest wait on any handshake or reset, in cycles
  localparam int WAIT_MAX = 20;

  logic                           adc_clk;
  logic                           top_rst;
  logic [CHN_NUM-1:0][ADC_DW-1:0] adc_dat;
  logic [CHN_NUM-1:0][DAC_DW-1:0] gen_dat;
  logic [CHN_NUM-1:0][ADC_DW-1:0] osc_dat;
  logic [DAC_DW-1:0]              dac_dat;
  logic                           dac_sel;
  logic [PDM_CHN-1:0]             pdm;
  logic                           cfg_req;
  logic [CFG_AW-1:0]              cfg_addr;
  logic [CFG_DW-1:0]              cfg_dat;
  logic                           cfg_ack;

  // model state, owned by the compare process
  logic [CHN_NUM-1:0][ADC_DW-1:0] adc_q;
  logic [CHN_NUM-1:0][DAC_DW-1:0] gen_q;
  logic [CHN_NUM-1:0][ADC_DW-1:0] exp_osc;
  logic [CHN_NUM-1:0][DAC_DW-1:0] exp_word;
  logic [DAC_DW-1:0]              exp_dac;
  logic                           exp_sel;
  logic                           exp_ack;
  logic [CHN_NUM-1:0]             loop_m;
  logic [PDM_CHN-1:0][PDM_DW-1:0] lvl_m;
  logic [PDM_CHN-1:0][PDM_DW-1:0] lvl_chk;

  logic [31:0] rng_state;

  tb_clk_gen u_tb_clk_gen (
    .clk_o (adc_clk),
    .rst_o (top_rst)
  );

  rp_loop_top u_rp_loop_top (
    .adc_clk    (adc_clk ),
    .top_rst    (top_rst ),
    .adc_dat_i  (adc_dat ),
    .gen_dat_i  (gen_dat ),
    .osc_dat_o  (osc_dat ),
    .dac_dat_o  (dac_dat ),
    .dac_sel_o  (dac_sel ),
    .pdm_o      (pdm     ),
    .cfg_req_i  (cfg_req ),
    .cfg_addr_i (cfg_addr),
    .cfg_dat_i  (cfg_dat ),
    .cfg_ack_o  (cfg_ack )
  );

  ////////////////////////////////////////////////////////////////////////////
  // reference and helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // negative slope offset binary to two's complement, or looped generator
  function automatic logic [ADC_DW-1:0] expect_osc(input logic loop,
                                                   input logic [ADC_DW-1:0] adc,
                                                   input logic [DAC_DW-1:0] gen);
    if (loop) begin
      return ADC_DW'(gen) << LOOP_SHIFT;
    end
    return adc ^ {1'b0, {(ADC_DW-1){1'b1}}};
  endfunction

  // two's complement back to the DAC code
  function automatic logic [DAC_DW-1:0] expect_dac(input logic [DAC_DW-1:0] gen);
    return gen ^ {1'b0, {(DAC_DW-1){1'b1}}};
  endfunction

  task automatic check_val(input logic [31:0] got, input logic [31:0] exp,
                           input string what);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
      $display("** FAIL **");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic abort_run(input string why);
    $display("Error at %0t ns: %s", $time, why);
    $display("** FAIL **");
    $fatal(1, "stopped on a timeout");
  endtask

  // one cycle: new random samples on the falling edge
  task automatic step();
    int i;
    @(negedge adc_clk);
    for (i = 0; i < CHN_NUM; i++) begin
      rng_state  = xorshift32(rng_state);
      adc_dat[i] = rng_state[15:0];
      gen_dat[i] = rng_state[29:16];
    end
  endtask

  // full four-phase write, data keeps flowing meanwhile
  task automatic cfg_write(input logic [CFG_AW-1:0] addr, input logic [CFG_DW-1:0] dat);
    int n;
    step();
    cfg_addr = addr;
    cfg_dat  = dat;
    cfg_req  = 1'b1;
    n = 0;
    while (cfg_ack !== 1'b1) begin
      step();
      n++;
      if (n > WAIT_MAX) abort_run("configuration ack did not rise after the request");
    end
    cfg_req = 1'b0;
    n = 0;
    while (cfg_ack !== 1'b0) begin
      step();
      n++;
      if (n > WAIT_MAX) abort_run("configuration ack did not fall after the request dropped");
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // model and compare
  ////////////////////////////////////////////////////////////////////////////

  initial begin : compare_proc
    int i;
    int j;
    forever begin
      // inputs are stable here, outputs are about to change
      @(posedge adc_clk);
      if (top_rst) begin
        exp_osc  = '0;
        exp_word = {CHN_NUM{DAC_IDLE}};
        exp_dac  = DAC_IDLE;
        exp_sel  = 1'b0;
        exp_ack  = 1'b0;
        loop_m   = '0;
        lvl_m    = '0;
        lvl_chk  = '0;
      end else begin
        lvl_chk = lvl_m;
        // loop bits in effect before this edge pick the source
        for (i = 0; i < CHN_NUM; i++) begin
          exp_osc[i] = expect_osc(loop_m[i], adc_q[i], gen_q[i]);
        end
        exp_sel = ~exp_sel;
        // channel 0 word while select is low
        exp_dac = exp_word[exp_sel];
        for (i = 0; i < CHN_NUM; i++) begin
          if (!loop_m[i]) exp_word[i] = expect_dac(gen_dat[i]);
        end
        // write lands on the edge that raises ack
        if (cfg_req && !exp_ack) begin
          case (cfg_addr)
            CFG_ADDR_LOOP: loop_m = cfg_dat[CHN_NUM-1:0];
            CFG_ADDR_PDM_LO: begin
              lvl_m[0] = cfg_dat[7:0];
              lvl_m[1] = cfg_dat[15:8];
            end
            CFG_ADDR_PDM_HI: begin
              lvl_m[2] = cfg_dat[7:0];
              lvl_m[3] = cfg_dat[15:8];
            end
            default: begin
              // unmapped, nothing changes
            end
          endcase
          exp_ack = 1'b1;
        end else if (!cfg_req) begin
          exp_ack = 1'b0;
        end
      end
      // raw input registers run through reset too
      adc_q = adc_dat;
      gen_q = gen_dat;
      @(negedge adc_clk);
      for (i = 0; i < CHN_NUM; i++) begin
        check_val(32'(osc_dat[i]), 32'(exp_osc[i]), $sformatf("osc_dat_o[%0d]", i));
      end
      check_val(32'(dac_dat), 32'(exp_dac), "dac_dat_o");
      check_val(32'(dac_sel), 32'(exp_sel), "dac_sel_o");
      check_val(32'(cfg_ack), 32'(exp_ack), "cfg_ack_o");
      // a zero level never carries
      for (j = 0; j < PDM_CHN; j++) begin
        if (lvl_chk[j] == '0) check_val(32'(pdm[j]), 32'd0, $sformatf("pdm_o[%0d]", j));
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin : stim_proc
    int                             n;
    int                             j;
    int                             pdm_cnt [PDM_CHN];
    logic [PDM_CHN-1:0][PDM_DW-1:0] lvl_set;
    rng_state = 32'hed8483ae;
    adc_dat   = '0;
    gen_dat   = '0;
    cfg_req   = 1'b0;
    cfg_addr  = '0;
    cfg_dat   = '0;

    n = 0;
    while (top_rst !== 1'b0) begin
      step();
      n++;
      if (n > WAIT_MAX) abort_run("reset was never released");
    end

    // plain capture and interleave
    repeat (200) step();

    // channel 1 looped back, reserved bits set
    cfg_write(CFG_ADDR_LOOP, 16'hbeb2);
    repeat (100) step();
    cfg_write(CFG_ADDR_LOOP, 16'h0000);
    repeat (50) step();
    // both channels looped
    cfg_write(CFG_ADDR_LOOP, 16'h7fff);
    repeat (50) step();
    cfg_write(CFG_ADDR_LOOP, 16'h0000);
    repeat (50) step();

    // random PDM levels, then a write to the unused address
    rng_state = xorshift32(rng_state);
    lvl_set   = rng_state;
    cfg_write(CFG_ADDR_PDM_LO, lvl_set[1:0]);
    cfg_write(CFG_ADDR_PDM_HI, lvl_set[3:2]);
    rng_state = xorshift32(rng_state);
    // loop bits set in the data, a stray decode would show on osc_dat_o
    cfg_write(2'd3, rng_state[15:0] | 16'h0003);
    repeat (256) step();

    for (j = 0; j < PDM_CHN; j++) pdm_cnt[j] = 0;
    repeat (256) begin
      step();
      for (j = 0; j < PDM_CHN; j++) begin
        if (pdm[j]) pdm_cnt[j]++;
      end
    end
    for (j = 0; j < PDM_CHN; j++) begin
      check_val(32'(pdm_cnt[j]), 32'(lvl_set[j]), $sformatf("pdm_o[%0d] high count", j));
    end

    repeat (10) step();
    $display("** PASS **");
    $finish;
  end

endmodule: tb_rp_loop_top

//--- rp_loop.f
hdl/rp_loop_pkg.sv
hdl/cfg_regs.sv
hdl/chan_path.sv
hdl/dac_interleave.sv
hdl/pdm_gen.sv
hdl/rp_loop_top.sv
test/tb_clk_gen.sv
test/tb_rp_loop_top.sv

//--- run_sim.sh
#!/bin/sh
# Build the front-end testbench with Verilator and run it.
# The result is taken from the pass line in sim.log.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --timescale 1ns/10ps \
  --top-module tb_rp_loop_top \
  -f rp_loop.f \
  -Mdir obj_dir -o tb_rp_loop_top

# tee keeps the log even when the simulation stops early
./obj_dir/tb_rp_loop_top 2>&1 | tee sim.log

if grep -q '^\*\* PASS \*\*$' sim.log; then
  echo "simulation passed"
else
  echo "simulation failed, see sim.log"
  exit 1
fi
